// ==== include/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry, direct mapped
`define DCACHE_LINES      32
`define DCACHE_INDEX_BITS 5

// memory model
`define MEM_LATENCY 4     // cycles from accepted load to tagged data
`define MEM_WORDS   8192  // 64-bit words, covers a 16-bit byte address

// bus commands
`define BUS_NONE  2'd0
`define BUS_LOAD  2'd1
`define BUS_STORE 2'd2

// access sizes in size[1:0], size[2] set means unsigned load
`define SIZE_BYTE   2'd0
`define SIZE_HALF   2'd1
`define SIZE_WORD   2'd2
`define SIZE_DOUBLE 2'd3

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_params.svh"

package dcache_pkg;

	// byte address, only bits 15:0 reach the cache and memory
	typedef logic [31:0] addr_t;

	// line index, address bits 7:3
	typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;

	// remaining address bits up to 15
	typedef logic [12-`DCACHE_INDEX_BITS:0] cache_tag_t;

	// one cache line, also one memory word
	typedef logic [63:0] line_t;

	// memory transaction tag, zero means none
	typedef logic [3:0] mem_tag_t;

	// BUS_NONE, BUS_LOAD, BUS_STORE
	typedef logic [1:0] bus_cmd_t;

	// size code in bits 1:0, unsigned flag in bit 2
	typedef logic [2:0] mem_size_t;

endpackage

// ==== src/dcache_mem_if.sv ====
`timescale 1ns/1ps

interface dcache_mem_if;
	import dcache_pkg::*;

	bus_cmd_t command; // cache to memory
	addr_t    addr;    // 8-byte aligned
	line_t    wdata;

	mem_tag_t response; // nonzero when the command is accepted
	line_t    rdata;
	mem_tag_t data_tag; // tag of rdata, zero when nothing returns

	modport cache (
		output command,
		output addr,
		output wdata,
		input  response,
		input  rdata,
		input  data_tag
	);

	modport memory (
		input  command,
		input  addr,
		input  wdata,
		output response,
		output rdata,
		output data_tag
	);

endinterface

// ==== src/dcache_lane.sv ====
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_lane (
	input  dcache_pkg::line_t     line,
	input  logic [2:0]            addr_low,
	input  dcache_pkg::mem_size_t size,
	input  dcache_pkg::line_t     wdata,
	output dcache_pkg::line_t     load_data,
	output dcache_pkg::line_t     merged_line
);

	logic        unsigned_load;
	logic [7:0]  byte_val;
	logic [15:0] half_val;
	logic [31:0] word_val;

	assign unsigned_load = size[2];

	// addressed lanes, offsets assumed aligned to the size
	assign byte_val = line[{addr_low, 3'b000} +: 8];
	assign half_val = line[{addr_low[2:1], 4'b0000} +: 16];
	assign word_val = line[{addr_low[2], 5'b00000} +: 32];

	always_comb begin
		load_data = line;
		case (size[1:0])
			`SIZE_BYTE:
				load_data = {{56{byte_val[7] & ~unsigned_load}}, byte_val};
			`SIZE_HALF:
				load_data = {{48{half_val[15] & ~unsigned_load}}, half_val};
			`SIZE_WORD:
				load_data = {{32{word_val[31] & ~unsigned_load}}, word_val};
			`SIZE_DOUBLE:
				load_data = line; // no extension for a full line
		endcase
	end

	// store merge, untouched lanes keep the line contents
	always_comb begin
		merged_line = line;
		case (size[1:0])
			`SIZE_BYTE:
				merged_line[{addr_low, 3'b000} +: 8] = wdata[7:0];
			`SIZE_HALF:
				merged_line[{addr_low[2:1], 4'b0000} +: 16] = wdata[15:0];
			`SIZE_WORD:
				merged_line[{addr_low[2], 5'b00000} +: 32] = wdata[31:0];
			`SIZE_DOUBLE:
				merged_line = wdata;
		endcase
	end

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache (
	input  logic                  clock,
	input  logic                  reset,
	input  dcache_pkg::bus_cmd_t  command,
	input  dcache_pkg::addr_t     addr,
	input  dcache_pkg::line_t     wdata,
	input  dcache_pkg::mem_size_t size,
	input  logic                  clear,
	output dcache_pkg::line_t     rdata,
	output logic                  valid_out,
	output logic                  finished,
	dcache_mem_if.cache           mem
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE, // hits complete here
		S_MISS, // victim write-back if dirty, then refill load
		S_WAIT  // refill in flight
	} state_t;

	line_t                    data_array [`DCACHE_LINES];
	cache_tag_t               tag_array  [`DCACHE_LINES];
	logic [`DCACHE_LINES-1:0] valid_bits;
	logic [`DCACHE_LINES-1:0] dirty_bits;

	state_t     state, state_next;
	index_t     cur_index, last_index;
	cache_tag_t cur_tag, last_tag;
	mem_tag_t   pend_tag; // tag of the outstanding refill

	logic   active, hit, miss, store_hit, victim_dirty;
	logic   changed_addr, abort, accepted, refill_done;
	logic   flush_found;
	index_t flush_index;
	line_t  merged_line;

	function automatic addr_t line_addr(input cache_tag_t tag, input index_t index);
		addr_t a;
		a = '0;
		a[15:3] = {tag, index};
		return a;
	endfunction

	assign {cur_tag, cur_index} = addr[15:3];

	assign active       = command != `BUS_NONE;
	assign hit          = active && valid_bits[cur_index] && (tag_array[cur_index] == cur_tag);
	assign miss         = active && !hit && !clear;
	assign store_hit    = hit && (command == `BUS_STORE) && !clear;
	assign victim_dirty = valid_bits[cur_index] && dirty_bits[cur_index];

	// requester moved on, drop whatever miss was in progress
	assign changed_addr = (cur_index != last_index) || (cur_tag != last_tag);
	assign abort        = clear || changed_addr || !active;

	assign accepted    = mem.response != '0;
	assign refill_done = (state == S_WAIT) && (pend_tag != '0) && (mem.data_tag == pend_tag);

	dcache_lane u_lane (
		.line        (data_array[cur_index]),
		.addr_low    (addr[2:0]),
		.size        (size),
		.wdata       (wdata),
		.load_data   (rdata),
		.merged_line (merged_line)
	);

	assign valid_out = hit && (command == `BUS_LOAD) && !clear;
	assign finished  = (hit && !clear) || (clear && !flush_found);

	// lowest dirty line for the flush
	always_comb begin
		flush_found = 1'b0;
		flush_index = '0;
		for (int i = `DCACHE_LINES - 1; i >= 0; i--) begin
			if (dirty_bits[i]) begin
				flush_found = 1'b1;
				flush_index = index_t'(i);
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:
				if (miss) state_next = S_MISS;
			S_MISS: begin
				if (abort)
					state_next = S_IDLE;
				else if (!victim_dirty && accepted)
					state_next = S_WAIT; // refill load taken
			end
			S_WAIT:
				if (abort || refill_done) state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
	end

	always_comb begin
		mem.command = `BUS_NONE;
		mem.addr    = '0;
		mem.wdata   = '0;
		if (clear) begin
			if (flush_found) begin
				mem.command = `BUS_STORE;
				mem.addr    = line_addr(tag_array[flush_index], flush_index);
				mem.wdata   = data_array[flush_index];
			end
		end else if (state == S_MISS && !abort) begin
			if (victim_dirty) begin
				mem.command = `BUS_STORE; // write back the victim first
				mem.addr    = line_addr(tag_array[cur_index], cur_index);
				mem.wdata   = data_array[cur_index];
			end else begin
				mem.command = `BUS_LOAD;
				mem.addr    = {addr[31:3], 3'b000};
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= S_IDLE;
			valid_bits <= '0;
			dirty_bits <= '0;
			last_index <= '0;
			last_tag   <= '0;
			pend_tag   <= '0;
		end else begin
			state      <= state_next;
			last_index <= cur_index;
			last_tag   <= cur_tag;

			if (state == S_MISS && mem.command == `BUS_LOAD && accepted)
				pend_tag <= mem.response;

			if (clear && flush_found && accepted)
				dirty_bits[flush_index] <= 1'b0;
			else if (state == S_MISS && mem.command == `BUS_STORE && accepted)
				dirty_bits[cur_index] <= 1'b0;

			if (refill_done && !abort) begin
				valid_bits[cur_index] <= 1'b1;
				dirty_bits[cur_index] <= 1'b0;
			end else if (store_hit) begin
				dirty_bits[cur_index] <= 1'b1;
			end
		end
	end

	// line payload
	always_ff @(posedge clock) begin
		if (refill_done && !abort) begin
			data_array[cur_index] <= mem.rdata;
			tag_array[cur_index]  <= cur_tag;
		end else if (store_hit) begin
			data_array[cur_index] <= merged_line;
		end
	end

endmodule

// ==== src/mem_tagged.sv ====
`timescale 1ns/1ps
`include "dcache_params.svh"

module mem_tagged (
	input logic          clock,
	input logic          reset,
	dcache_mem_if.memory bus
);
	import dcache_pkg::*;

	localparam int WORD_BITS = $clog2(`MEM_WORDS);

	line_t    memory [`MEM_WORDS];
	mem_tag_t next_tag; // handed out on the next accepted command

	// delay line, last stage drives the data return
	mem_tag_t stage_tag  [`MEM_LATENCY];
	line_t    stage_data [`MEM_LATENCY];

	logic [WORD_BITS-1:0] word_index;
	logic                 accept;
	logic                 is_load;
	logic                 is_store;

	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			memory[i] = '0;
		end
	end

	assign word_index = bus.addr[WORD_BITS+2:3]; // upper address bits ignored
	assign accept     = bus.command != `BUS_NONE;
	assign is_load    = bus.command == `BUS_LOAD;
	assign is_store   = bus.command == `BUS_STORE;

	assign bus.response = accept ? next_tag : '0;
	assign bus.rdata    = stage_data[`MEM_LATENCY-1];
	assign bus.data_tag = stage_tag[`MEM_LATENCY-1];

	// tags run 1..15, zero is reserved
	always_ff @(posedge clock) begin
		if (reset) begin
			next_tag <= mem_tag_t'(1);
		end else if (accept) begin
			if (next_tag == '1)
				next_tag <= mem_tag_t'(1);
			else
				next_tag <= next_tag + mem_tag_t'(1);
		end
	end

	always @(posedge clock) begin
		if (is_store)
			memory[word_index] <= bus.wdata;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `MEM_LATENCY; i++) begin
				stage_tag[i] <= '0;
			end
		end else begin
			stage_tag[0] <= is_load ? next_tag : '0;
			for (int i = 1; i < `MEM_LATENCY; i++) begin
				stage_tag[i] <= stage_tag[i-1];
			end
		end
	end

	// read at accept time, data rides along with its tag
	always_ff @(posedge clock) begin
		stage_data[0] <= memory[word_index];
		for (int i = 1; i < `MEM_LATENCY; i++) begin
			stage_data[i] <= stage_data[i-1];
		end
	end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
	input  logic                  clock,
	input  logic                  reset,
	input  dcache_pkg::bus_cmd_t  command,
	input  dcache_pkg::addr_t     addr,
	input  dcache_pkg::line_t     wdata,
	input  dcache_pkg::mem_size_t size,
	input  logic                  clear,
	output dcache_pkg::line_t     rdata,
	output logic                  valid_out,
	output logic                  finished
);

	dcache_mem_if mem_bus ();

	// execute stage side
	dcache u_dcache (
		.clock     (clock),
		.reset     (reset),
		.command   (command),
		.addr      (addr),
		.wdata     (wdata),
		.size      (size),
		.clear     (clear),
		.rdata     (rdata),
		.valid_out (valid_out),
		.finished  (finished),
		.mem       (mem_bus.cache)
	);

	// backing store behind the cache
	mem_tagged u_mem (
		.clock (clock),
		.reset (reset),
		.bus   (mem_bus.memory)
	);

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb;
	import dcache_pkg::*;

	localparam int        timeout_cycles = 200;
	localparam mem_size_t dbl_size       = {1'b0, `SIZE_DOUBLE};

	logic      clock;
	logic      reset;
	bus_cmd_t  command;
	addr_t     addr;
	line_t     wdata;
	mem_size_t size;
	logic      clear;
	line_t     rdata;
	logic      valid_out;
	logic      finished;

	logic [7:0]  shadow [65536]; // byte image of the 16-bit address space
	addr_t       stored_lines [$];
	logic [31:0] seed;
	logic        finished_q; // finished at the last rising edge
	logic        load_check;
	line_t       expected_data;
	int          errors;
	int          timeouts;
	int          loads_checked;

	dcache_top DUT (
		.clock     (clock),
		.reset     (reset),
		.command   (command),
		.addr      (addr),
		.wdata     (wdata),
		.size      (size),
		.clear     (clear),
		.rdata     (rdata),
		.valid_out (valid_out),
		.finished  (finished)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) finished_q <= finished;

	idle_quiet: assert property (@(posedge clock) disable iff (reset)
		(command == `BUS_NONE && !clear) |-> (!valid_out && !finished))
	else begin
		errors++;
		$display("[ERROR] valid_out=%h finished=%h while idle, expected 0 and 0",
			$sampled(valid_out), $sampled(finished));
	end

	load_valid: assert property (@(posedge clock) disable iff (reset)
		(load_check && finished) |-> valid_out)
	else begin
		errors++;
		$display("[ERROR] valid_out: got %h expected 1 at addr %h",
			$sampled(valid_out), $sampled(addr));
	end

	load_data: assert property (@(posedge clock) disable iff (reset)
		(load_check && finished) |-> (rdata == expected_data))
	else begin
		errors++;
		$display("[ERROR] rdata: got %h expected %h at addr %h size %h",
			$sampled(rdata), $sampled(expected_data), $sampled(addr), $sampled(size));
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// little-endian bytes, sign from the top byte unless size[2]
	function automatic line_t expected_load(input addr_t a, input mem_size_t sz);
		int          nbytes;
		line_t       value;
		logic [15:0] byte_addr;
		nbytes = 1 << sz[1:0];
		value  = '0;
		for (int i = 0; i < nbytes; i++) begin
			byte_addr = a[15:0] + 16'(i);
			value     = value | (line_t'(shadow[byte_addr]) << (8 * i));
		end
		if (!sz[2] && nbytes < 8 && ((value >> (8 * nbytes - 1)) & 64'd1) != 64'd0)
			value = value | (~64'd0 << (8 * nbytes));
		return value;
	endfunction

	function automatic void write_shadow(input addr_t a, input mem_size_t sz, input line_t data);
		int          nbytes;
		logic [15:0] byte_addr;
		nbytes = 1 << sz[1:0];
		for (int i = 0; i < nbytes; i++) begin
			byte_addr         = a[15:0] + 16'(i);
			shadow[byte_addr] = 8'(data >> (8 * i));
		end
	endfunction

	task automatic wait_for_finished(input string what, input addr_t a);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!finished_q && cycles < timeout_cycles);
		if (!finished_q) begin
			timeouts++;
			$display("timeout: %s at address %h did not finish within %0d cycles",
				what, a, timeout_cycles);
		end
	endtask

	// called on a falling edge, returns on the falling edge after completion
	task automatic run_access(input bus_cmd_t cmd, input addr_t a, input mem_size_t sz,
		input line_t data);
		addr_t aligned;
		aligned = a & ~((32'd1 << sz[1:0]) - 32'd1);
		command = cmd;
		addr    = aligned;
		size    = sz;
		wdata   = data;
		if (cmd == `BUS_LOAD) begin
			expected_data = expected_load(aligned, sz);
			load_check    = 1'b1;
			loads_checked++;
		end
		wait_for_finished(cmd == `BUS_LOAD ? "load" : "store", aligned);
		load_check = 1'b0;
		if (cmd == `BUS_STORE) begin
			write_shadow(aligned, sz, data);
			stored_lines.push_back({aligned[31:3], 3'b000});
		end
	endtask

	initial begin
		logic [31:0] r;
		int          n;
		int          s;
		int          off;
		reset = 1'b1;
		command = `BUS_NONE;
		addr = '0;
		wdata = '0;
		size = '0;
		clear = 1'b0;
		load_check = 1'b0;
		expected_data = '0;
		errors = 0;
		timeouts = 0;
		loads_checked = 0;
		seed = 32'hc55b5107;
		for (n = 0; n < 65536; n++) shadow[16'(n)] = 8'h00; // memory model starts at zero
		repeat (16) @(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock); // idle, outputs must stay low

		run_access(`BUS_STORE, 32'h0000_0100, dbl_size, 64'h0123_4567_89ab_cdef);
		run_access(`BUS_LOAD, 32'h0000_0100, dbl_size, '0);

		// every lane and size, signed then unsigned
		run_access(`BUS_STORE, 32'h0000_0400, dbl_size, 64'h80ff_7f01_c33c_a55a);
		for (s = 0; s < 4; s++) begin
			for (off = 0; off < 8; off += (1 << s)) begin
				run_access(`BUS_LOAD, 32'h0000_0400 + 32'(off), {1'b0, 2'(s)}, '0);
				run_access(`BUS_LOAD, 32'h0000_0400 + 32'(off), {1'b1, 2'(s)}, '0);
			end
		end

		// sized stores, full line read back each time
		run_access(`BUS_STORE, 32'h0000_0408, dbl_size, 64'h1122_3344_5566_7788);
		for (s = 0; s < 3; s++) begin
			for (off = 0; off < 8; off += (1 << s)) begin
				run_access(`BUS_STORE, 32'h0000_0408 + 32'(off), {1'b0, 2'(s)},
					{next_random(), next_random()});
				run_access(`BUS_LOAD, 32'h0000_0408, dbl_size, '0);
			end
		end

		// same index, other tag, forces a dirty victim out
		run_access(`BUS_STORE, 32'h0000_1040, dbl_size, 64'hdead_beef_0bad_f00d);
		run_access(`BUS_STORE, 32'h0000_1140, dbl_size, 64'h5a5a_0000_ffff_a5a5);
		run_access(`BUS_LOAD, 32'h0000_1040, dbl_size, '0);
		run_access(`BUS_LOAD, 32'h0000_1144, {1'b0, `SIZE_WORD}, '0);

		// 1 KB window, four tags per index
		for (n = 0; n < 300; n++) begin
			r = next_random();
			if (r[16])
				run_access(`BUS_STORE, {22'h0, r[9:0]}, {1'b0, r[11:10]},
					{next_random(), next_random()});
			else
				run_access(`BUS_LOAD, {22'h0, r[9:0]}, r[12:10], '0);
		end

		// flush, drop the cache contents, then read everything back from memory
		command = `BUS_NONE;
		clear = 1'b1;
		wait_for_finished("clear", '0);
		clear = 1'b0;
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		foreach (stored_lines[k]) run_access(`BUS_LOAD, stored_lines[k], dbl_size, '0);

		command = `BUS_NONE;
		repeat (2) @(negedge clock);
		$display("checks done: %0d errors, %0d timeouts, %0d loads checked",
			errors, timeouts, loads_checked);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
src/dcache_pkg.sv
src/dcache_mem_if.sv
src/dcache_lane.sv
src/dcache.sv
src/mem_tagged.sv
src/dcache_top.sv
tb/dcache_tb.sv

// ==== Makefile ====
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): flist.f include/dcache_params.svh src/*.sv tb/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP) -f flist.f

# the log decides, the simulator exit code alone is not enough
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
